/* include/upcfg_cfg.svh */
`ifndef UPCFG_CFG_SVH
`define UPCFG_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link capability and LTSSM encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define UPCFG_CAP_LINK_WIDTH 4'd8   // widest link the port can train to.
`define UPCFG_LTSSM_CFG_IDLE 6'h20  // Configuration.Idle.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// filter window lengths, last counter value of the window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// set to 1 for the short fast-train window.
`define UPCFG_FAST_TRAIN 1'b0

`define UPCFG_WIN_FAST 16'd225
`define UPCFG_WIN_GEN1 16'd400      // 2.5 GT/s.
`define UPCFG_WIN_GEN2 16'd800      // 5.0 GT/s.

`endif

/* hw/upcfg_pkg.sv */
package upcfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // side-band vectors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [5:0]  ltssm_t;       // LTSSM state code.
  typedef logic [3:0]  link_width_t;  // negotiated lane count.
  typedef logic [1:0]  dir_change_t;  // directed link change request.
  typedef logic [15:0] win_count_t;   // filter window counter.

  // one lane-0 PIPE receive word, two symbols.
  typedef struct packed {
    logic [15:0] data;
    logic [1:0]  char_isk;
  } rx_word_t;

  // per-byte symbol classes of one word.
  typedef struct packed {
    logic com0;
    logic pad0;
    logic com1;
    logic pad1;
  } sym_class_t;

  typedef enum logic [1:0] {
    WIN_IDLE   = 2'd0,  // armed, waiting for a trigger.
    WIN_FILTER = 2'd1,  // window open, lane 0 is blanked.
    WIN_SPENT  = 2'd2   // used up for this Configuration.Idle visit.
  } win_state_t;

endpackage

/* hw/rx_symbol_classify.sv */
`timescale 1ns/1ps

module rx_symbol_classify (
  input  logic                  pipe_clk,
  input  logic                  rst_n,
  input  upcfg_pkg::rx_word_t   rx_in,
  output upcfg_pkg::rx_word_t   rx_q,
  output upcfg_pkg::sym_class_t cls_q
);

  localparam logic [7:0] k28_5 = 8'hBC;  // COM.
  localparam logic [7:0] k23_7 = 8'hF7;  // PAD.

  upcfg_pkg::sym_class_t cls;

  // a control symbol only counts when its K bit is set.
  function automatic logic is_k_code(
    input logic [7:0] sym,
    input logic       isk,
    input logic [7:0] code
  );
    return isk && (sym == code);
  endfunction

  always_comb begin
    cls.com0 = is_k_code(rx_in.data[7:0],  rx_in.char_isk[0], k28_5);
    cls.pad0 = is_k_code(rx_in.data[7:0],  rx_in.char_isk[0], k23_7);
    cls.com1 = is_k_code(rx_in.data[15:8], rx_in.char_isk[1], k28_5);
    cls.pad1 = is_k_code(rx_in.data[15:8], rx_in.char_isk[1], k23_7);
  end

  // word and classes stay aligned in the same register stage.
  always_ff @(posedge pipe_clk) begin
    if (!rst_n) begin
      rx_q  <= '0;
      cls_q <= '0;
    end else begin
      rx_q  <= rx_in;
      cls_q <= cls;
    end
  end

endmodule

/* hw/com_pad_detect.sv */
`timescale 1ns/1ps

module com_pad_detect (
  input  logic                  pipe_clk,
  input  logic                  rst_n,
  input  upcfg_pkg::rx_word_t   rx_d,
  input  upcfg_pkg::sym_class_t cls_d,
  output upcfg_pkg::rx_word_t   rx_q,
  output logic                  seq_hit
);

  upcfg_pkg::sym_class_t prev_cls;  // classes of the word before cls_d.
  logic                  hit_a;
  logic                  hit_b;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // COM, PAD, PAD across two consecutive words
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // COM in the upper byte, both PADs in the next word.
  assign hit_a = prev_cls.com1 && cls_d.pad0 && cls_d.pad1;

  // COM, PAD in one word, second PAD in the low byte of the next.
  assign hit_b = prev_cls.com0 && prev_cls.pad1 && cls_d.pad0;

  always_ff @(posedge pipe_clk) begin
    if (!rst_n) begin
      prev_cls <= '0;
      seq_hit  <= 1'b0;
    end else begin
      prev_cls <= cls_d;
      seq_hit  <= hit_a || hit_b;  // one-cycle strobe per sequence.
    end
  end

  // the word moves with seq_hit so stage 3 sees both together.
  always_ff @(posedge pipe_clk) begin
    if (!rst_n) begin
      rx_q <= '0;
    end else begin
      rx_q <= rx_d;
    end
  end

endmodule

/* hw/tsx_filter_window.sv */
`timescale 1ns/1ps
`include "upcfg_cfg.svh"

module tsx_filter_window (
  input  logic                   pipe_clk,
  input  logic                   rst_n,
  input  logic                   phy_lnkup_n,
  input  upcfg_pkg::ltssm_t      ltssm_state,
  input  upcfg_pkg::link_width_t negotiated_width,
  input  upcfg_pkg::dir_change_t directed_change,
  input  logic                   sel_lnk_rate,
  input  logic                   seq_hit,
  input  upcfg_pkg::rx_word_t    rx_d,
  output upcfg_pkg::rx_word_t    rx_q,
  output logic                   filter_active
);

  localparam upcfg_pkg::link_width_t cap_width   = `UPCFG_CAP_LINK_WIDTH;
  localparam upcfg_pkg::ltssm_t      cfg_idle    = `UPCFG_LTSSM_CFG_IDLE;
  localparam logic                   fast_train  = `UPCFG_FAST_TRAIN;
  localparam upcfg_pkg::win_count_t  win_fast    = `UPCFG_WIN_FAST;
  localparam upcfg_pkg::win_count_t  win_gen1    = `UPCFG_WIN_GEN1;
  localparam upcfg_pkg::win_count_t  win_gen2    = `UPCFG_WIN_GEN2;

  upcfg_pkg::win_state_t state;
  upcfg_pkg::win_count_t win_count;
  upcfg_pkg::win_count_t win_limit;
  logic                  in_cfg_idle;
  logic                  trigger;

  assign in_cfg_idle = (ltssm_state == cfg_idle);

  // rate select may change mid-window, so the limit follows it each cycle.
  assign win_limit = fast_train ? win_fast : (sel_lnk_rate ? win_gen2 : win_gen1);

  assign trigger = seq_hit
                && !phy_lnkup_n
                && in_cfg_idle
                && (negotiated_width != cap_width)  // only a narrowed link can up-configure.
                && (directed_change == 2'b00)
                && (state == upcfg_pkg::WIN_IDLE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // window state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge pipe_clk) begin
    if (!rst_n || phy_lnkup_n) begin
      state     <= upcfg_pkg::WIN_IDLE;  // link loss disarms everything.
      win_count <= '0;
    end else begin
      case (state)
        upcfg_pkg::WIN_IDLE: begin
          if (trigger) begin
            state     <= upcfg_pkg::WIN_FILTER;
            win_count <= '0;
          end
        end
        upcfg_pkg::WIN_FILTER: begin
          if (win_count < win_limit) begin
            win_count <= win_count + 16'd1;
          end else begin
            win_count <= '0;
            // stay spent until the LTSSM leaves Configuration.Idle.
            state     <= in_cfg_idle ? upcfg_pkg::WIN_SPENT : upcfg_pkg::WIN_IDLE;
          end
        end
        upcfg_pkg::WIN_SPENT: begin
          if (!in_cfg_idle) begin
            state <= upcfg_pkg::WIN_IDLE;
          end
        end
        default: begin
          state     <= upcfg_pkg::WIN_IDLE;
          win_count <= '0;
        end
      endcase
    end
  end

  assign filter_active = (state == upcfg_pkg::WIN_FILTER);

  always_ff @(posedge pipe_clk) begin
    if (!rst_n) begin
      rx_q <= '0;
    end else begin
      rx_q <= rx_d;  // lines the word up with filter_active.
    end
  end

endmodule

/* hw/rx_pipe_gate.sv */
`timescale 1ns/1ps

module rx_pipe_gate (
  input  logic                pipe_clk,
  input  logic                rst_n,
  input  upcfg_pkg::rx_word_t rx_d,
  input  logic                filter_active,
  output upcfg_pkg::rx_word_t rx_out
);

  upcfg_pkg::rx_word_t gated;

  // data and K flags are both blanked, so the core sees a plain zero word.
  always_comb begin
    if (filter_active) begin
      gated = '0;
    end else begin
      gated = rx_d;
    end
  end

  always_ff @(posedge pipe_clk) begin
    if (!rst_n) begin
      rx_out <= '0;
    end else begin
      rx_out <= gated;
    end
  end

endmodule

/* hw/upcfg_filter_top.sv */
`timescale 1ns/1ps

module upcfg_filter_top (
  input  logic                   pipe_clk,
  input  logic                   rst_n,
  input  logic                   phy_lnkup_n,
  input  upcfg_pkg::ltssm_t      ltssm_state,
  input  upcfg_pkg::link_width_t negotiated_width,
  input  upcfg_pkg::dir_change_t directed_change,
  input  logic                   sel_lnk_rate,
  input  upcfg_pkg::rx_word_t    rx_in,
  output upcfg_pkg::rx_word_t    rx_out,
  output logic                   filter_pipe
);

  upcfg_pkg::rx_word_t   rx_s1;
  upcfg_pkg::sym_class_t cls_s1;
  upcfg_pkg::rx_word_t   rx_s2;
  logic                  seq_hit;
  upcfg_pkg::rx_word_t   rx_s3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // four-stage receive pipeline, one word per pipe_clk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  rx_symbol_classify u_classify (
    .pipe_clk (pipe_clk),
    .rst_n    (rst_n),
    .rx_in    (rx_in),
    .rx_q     (rx_s1),
    .cls_q    (cls_s1)
  );

  com_pad_detect u_detect (
    .pipe_clk (pipe_clk),
    .rst_n    (rst_n),
    .rx_d     (rx_s1),
    .cls_d    (cls_s1),
    .rx_q     (rx_s2),
    .seq_hit  (seq_hit)
  );

  tsx_filter_window u_window (
    .pipe_clk         (pipe_clk),
    .rst_n            (rst_n),
    .phy_lnkup_n      (phy_lnkup_n),
    .ltssm_state      (ltssm_state),
    .negotiated_width (negotiated_width),
    .directed_change  (directed_change),
    .sel_lnk_rate     (sel_lnk_rate),
    .seq_hit          (seq_hit),
    .rx_d             (rx_s2),
    .rx_q             (rx_s3),
    .filter_active    (filter_pipe)  // leads the gated word by one cycle.
  );

  rx_pipe_gate u_gate (
    .pipe_clk      (pipe_clk),
    .rst_n         (rst_n),
    .rx_d          (rx_s3),
    .filter_active (filter_pipe),
    .rx_out        (rx_out)
  );

endmodule

/* dv/upcfg_filter_sva.sv */
`timescale 1ns/1ps

module upcfg_filter_sva (
  input logic                pipe_clk,
  input logic                rst_n,
  input logic                seq_hit,
  input logic                filter_pipe,
  input upcfg_pkg::rx_word_t rx_out
);

  logic [9:0] high_run;  // consecutive cycles with the filter open.
  int         assert_fails = 0;  // number of failed assertions.

  always_ff @(posedge pipe_clk) begin
    if (!rst_n || !filter_pipe) begin
      high_run <= '0;
    end else begin
      high_run <= high_run + 10'd1;
    end
  end

  a_reset_quiet: assert property (@(posedge pipe_clk) !rst_n |=> !filter_pipe)
    else begin
      assert_fails++;
      $error("filter_pipe high after reset");
    end

  a_rise_needs_hit: assert property (@(posedge pipe_clk) disable iff (!rst_n)
    $rose(filter_pipe) |-> $past(seq_hit))
    else begin
      assert_fails++;
      $error("filter window opened without a sequence hit");
    end

  a_gated_zero: assert property (@(posedge pipe_clk) disable iff (!rst_n)
    filter_pipe |=> (rx_out == '0))
    else begin
      assert_fails++;
      $error("rx_out not blanked behind an open filter window");
    end

  a_window_len: assert property (@(posedge pipe_clk) disable iff (!rst_n)
    high_run <= 10'd801)
    else begin
      assert_fails++;
      $error("filter window longer than 801 cycles");
    end

endmodule

bind upcfg_filter_top upcfg_filter_sva u_sva (
  .pipe_clk    (pipe_clk),
  .rst_n       (rst_n),
  .seq_hit     (seq_hit),
  .filter_pipe (filter_pipe),
  .rx_out      (rx_out)
);

/* dv/upcfg_filter_tb.sv */
`timescale 1ns/1ps
`include "upcfg_cfg.svh"

module upcfg_filter_tb;

  localparam logic [7:0]        com         = 8'hBC;
  localparam logic [7:0]        pad         = 8'hF7;
  localparam upcfg_pkg::ltssm_t cfg_idle    = `UPCFG_LTSSM_CFG_IDLE;
  localparam upcfg_pkg::ltssm_t other_state = 6'h11;  // any state outside Configuration.Idle.
  // reset, settle, windows, blocked triggers, link drop and the random rounds.
  localparam int run_cycles = 10 + 20 + 1250 + 60 + 70 + 8 * 102;

  typedef struct packed {
    upcfg_pkg::rx_word_t   hist0;  // word held in stage 1.
    upcfg_pkg::rx_word_t   hist1;
    upcfg_pkg::rx_word_t   hist2;
    upcfg_pkg::win_state_t st;
    upcfg_pkg::win_count_t cnt;
    upcfg_pkg::rx_word_t   out;
  } ref_state_t;

  logic                   pipe_clk;
  logic                   rst_n;
  logic                   phy_lnkup_n;
  upcfg_pkg::ltssm_t      ltssm_state;
  upcfg_pkg::link_width_t negotiated_width;
  upcfg_pkg::dir_change_t directed_change;
  logic                   sel_lnk_rate;
  upcfg_pkg::rx_word_t    rx_in;
  upcfg_pkg::rx_word_t    rx_out;
  logic                   filter_pipe;
  ref_state_t             model;
  logic                   model_valid;
  logic [31:0]            rnd;
  int                     word_errors;
  int                     filter_errors;

  upcfg_filter_top DUT (
    .pipe_clk         (pipe_clk),
    .rst_n            (rst_n),
    .phy_lnkup_n      (phy_lnkup_n),
    .ltssm_state      (ltssm_state),
    .negotiated_width (negotiated_width),
    .directed_change  (directed_change),
    .sel_lnk_rate     (sel_lnk_rate),
    .rx_in            (rx_in),
    .rx_out           (rx_out),
    .filter_pipe      (filter_pipe)
  );

  function automatic logic byte_is_k(input upcfg_pkg::rx_word_t w, input int lane,
                                     input logic [7:0] code);
    return w.char_isk[lane] && (w.data[lane*8 +: 8] == code);
  endfunction

  // COM, PAD, PAD split over previous word p and current word c.
  function automatic logic seq_pattern(input upcfg_pkg::rx_word_t p,
                                       input upcfg_pkg::rx_word_t c);
    logic align_a;
    logic align_b;
    align_a = byte_is_k(p, 1, com) && byte_is_k(c, 0, pad) && byte_is_k(c, 1, pad);
    align_b = byte_is_k(p, 0, com) && byte_is_k(p, 1, pad) && byte_is_k(c, 0, pad);
    return align_a || align_b;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model, one call per rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic ref_state_t upcfg_ref(input ref_state_t m, input logic rst,
      input logic lnkup_n, input upcfg_pkg::ltssm_t ltssm, input upcfg_pkg::link_width_t width,
      input upcfg_pkg::dir_change_t dc, input logic rate, input upcfg_pkg::rx_word_t word);
    ref_state_t            n;
    logic                  hit;
    logic                  in_idle;
    upcfg_pkg::win_count_t limit;
    n       = m;
    hit     = seq_pattern(m.hist2, m.hist1);  // strobe for the word now entering stage 3.
    in_idle = (ltssm == cfg_idle);
    limit   = `UPCFG_FAST_TRAIN ? `UPCFG_WIN_FAST : (rate ? `UPCFG_WIN_GEN2 : `UPCFG_WIN_GEN1);
    if (m.st == upcfg_pkg::WIN_FILTER) begin
      n.out = '0;
    end else begin
      n.out = m.hist2;
    end
    if (lnkup_n) begin
      n.st  = upcfg_pkg::WIN_IDLE;
      n.cnt = '0;
    end else if (m.st == upcfg_pkg::WIN_IDLE) begin
      if (hit && in_idle && width != `UPCFG_CAP_LINK_WIDTH && dc == 2'b00) begin
        n.st  = upcfg_pkg::WIN_FILTER;
        n.cnt = '0;
      end
    end else if (m.st == upcfg_pkg::WIN_FILTER) begin
      if (m.cnt < limit) begin
        n.cnt = m.cnt + 16'd1;
      end else begin
        n.cnt = '0;
        n.st  = in_idle ? upcfg_pkg::WIN_SPENT : upcfg_pkg::WIN_IDLE;
      end
    end else if (!in_idle) begin
      n.st = upcfg_pkg::WIN_IDLE;
    end
    n.hist2 = m.hist1;
    n.hist1 = m.hist0;
    n.hist0 = word;
    if (!rst) begin
      n = '0;
    end
    return n;
  endfunction

  // background data, K bit dropped on COM and PAD codes.
  function automatic upcfg_pkg::rx_word_t rand_word();
    upcfg_pkg::rx_word_t w;
    logic [31:0]         r;
    r          = $urandom;
    w.data     = r[15:0];
    w.char_isk = r[17:16];
    for (int b = 0; b < 2; b++) begin
      if (w.data[b*8 +: 8] == com || w.data[b*8 +: 8] == pad) begin
        w.char_isk[b] = 1'b0;
      end
    end
    return w;
  endfunction

  task automatic check_word(input upcfg_pkg::rx_word_t got, input upcfg_pkg::rx_word_t exp);
    if (got !== exp) begin
      word_errors++;
      $display("ERROR %0t ns: rx_out data=%h isk=%b, expected data=%h isk=%b",
               $time, got.data, got.char_isk, exp.data, exp.char_isk);
    end
  endtask

  task automatic check_filter(input logic got, input logic exp);
    if (got !== exp) begin
      filter_errors++;
      $display("ERROR %0t ns: filter_pipe=%b, expected %b", $time, got, exp);
    end
  endtask

  task automatic send_background(input int n);
    repeat (n) begin
      rx_in = rand_word();
      @(negedge pipe_clk);
    end
  endtask

  task automatic send_seq(input logic align_b);
    upcfg_pkg::rx_word_t p;
    upcfg_pkg::rx_word_t c;
    p = rand_word();
    c = rand_word();
    if (align_b) begin
      p.data          = {pad, com};
      p.char_isk      = 2'b11;
      c.data[7:0]     = pad;
      c.char_isk[0]   = 1'b1;
    end else begin
      p.data[15:8]    = com;
      p.char_isk[1]   = 1'b1;
      c.data          = {pad, pad};
      c.char_isk      = 2'b11;
    end
    rx_in = p;
    @(negedge pipe_clk);
    rx_in = c;
    @(negedge pipe_clk);
  endtask

  initial begin
    pipe_clk = 1'b0;
    forever #20 pipe_clk = ~pipe_clk;
  end

  always @(posedge pipe_clk) begin
    model       = upcfg_ref(model, rst_n, phy_lnkup_n, ltssm_state, negotiated_width,
                            directed_change, sel_lnk_rate, rx_in);
    model_valid = 1'b1;
  end

  always @(negedge pipe_clk) begin
    if (model_valid) begin
      check_word(rx_out, model.out);
      check_filter(filter_pipe, model.st == upcfg_pkg::WIN_FILTER);
    end
  end

  initial begin
    #(run_cycles * 40 + 4000);
    $display("timeout: stimulus did not finish within %0d clock cycles", run_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    void'($urandom(32'h36cd9c33));
    model            = '0;
    model_valid      = 1'b0;
    word_errors      = 0;
    filter_errors    = 0;
    rst_n            = 1'b0;
    phy_lnkup_n      = 1'b0;
    ltssm_state      = cfg_idle;
    negotiated_width = 4'd4;
    directed_change  = 2'b00;
    sel_lnk_rate     = 1'b0;
    rx_in            = '0;
    repeat (10) @(posedge pipe_clk);
    @(negedge pipe_clk);
    rst_n = 1'b1;
    send_background(20);
    send_seq(1'b0);                  // gen1 window, second sequences are ignored.
    send_background(100);
    send_seq(1'b1);
    send_background(310);
    send_seq(1'b0);
    send_background(10);
    ltssm_state = other_state;       // leaving Configuration.Idle rearms the window.
    send_background(5);
    ltssm_state = cfg_idle;
    send_background(5);
    sel_lnk_rate = 1'b1;
    send_seq(1'b1);
    send_background(810);
    ltssm_state = other_state;
    send_background(3);
    ltssm_state      = cfg_idle;
    sel_lnk_rate     = 1'b0;
    negotiated_width = `UPCFG_CAP_LINK_WIDTH;
    send_seq(1'b0);
    send_background(10);
    negotiated_width = 4'd4;
    directed_change  = 2'b01;
    send_seq(1'b1);
    send_background(10);
    directed_change = 2'b00;
    ltssm_state     = other_state;
    send_seq(1'b0);
    send_background(10);
    ltssm_state = cfg_idle;
    phy_lnkup_n = 1'b1;
    send_seq(1'b1);
    send_background(10);
    phy_lnkup_n = 1'b0;
    send_background(4);
    send_seq(1'b0);
    send_background(50);
    phy_lnkup_n = 1'b1;              // link drop in the middle of a window.
    send_background(3);
    phy_lnkup_n = 1'b0;
    send_background(10);
    for (int i = 0; i < 8; i++) begin
      rnd              = $urandom;
      sel_lnk_rate     = rnd[0];
      negotiated_width = rnd[1] ? 4'd8 : 4'd4;
      directed_change  = (rnd[3:2] == 2'b00) ? 2'b10 : 2'b00;
      ltssm_state      = (rnd[5:4] == 2'b00) ? other_state : cfg_idle;
      send_seq(rnd[6]);
      send_background(int'(rnd[15:8]) % 100);
    end
    send_background(5);
    #5;
    $display("summary: %0d rx_out errors, %0d filter_pipe errors, %0d assertion failures",
             word_errors, filter_errors, DUT.u_sva.assert_fails);
    if (word_errors + filter_errors + DUT.u_sva.assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
hw/upcfg_pkg.sv
hw/rx_symbol_classify.sv
hw/com_pad_detect.sv
hw/tsx_filter_window.sv
hw/rx_pipe_gate.sv
hw/upcfg_filter_top.sv
dv/upcfg_filter_sva.sv
dv/upcfg_filter_tb.sv
